// File: verilog.f
+incdir+.
mm_ram_pkg.sv
mm_ram_decoder.sv
mm_ram_mem.sv
mm_ram_ctrl_regs.sv
mm_ram_timer.sv
mm_ram_rsp_mux.sv
mm_ram_top.sv
tb_mm_ram.sv

// File: tb_mm_ram_model.svh
/*
 * mm_ram reference model
 * byte array that mirrors accepted RAM writes, plus expected values for
 * data reads, instruction fetch lines, status pulses and the timer
 */
`ifndef TB_MM_RAM_MODEL_SVH
`define TB_MM_RAM_MODEL_SVH

// bytes never written stay X, as they do in the DUT
logic [7:0] model_mem [0:RAM_SIZE-1];

// initial contents of a test window word, built from all address bits
function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {~addr, addr ^ 16'hc3a5};
endfunction

function automatic void model_write(input logic [15:0] addr, input logic [3:0] be,
                                    input logic [31:0] wdata);
    int base;
    base = {addr[15:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            model_mem[base + b] = wdata[8*b +: 8];
        end
    end
endfunction

function automatic logic [31:0] model_read_word(input logic [15:0] addr);
    int          base;
    logic [31:0] word;
    base = {addr[15:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = model_mem[base + b];
    end
    return word;
endfunction

// four words from the 16-byte aligned line, lowest address in bits 31:0
function automatic logic [127:0] model_fetch_line(input logic [15:0] addr);
    int           base;
    logic [127:0] line;
    base = {addr[15:4], 4'b0000};
    for (int b = 0; b < 16; b++) begin
        line[8*b +: 8] = model_mem[base + b];
    end
    return line;
endfunction

// {passed, failed} pulse pair for a value written to the status register
function automatic logic [1:0] expected_status(input logic [31:0] value);
    return {value == 32'd123456789, value == 32'd1};
endfunction

// count seen by a read issued in rd_cyc after a load issued in load_cyc
function automatic logic [31:0] expected_count(input int n, input int load_cyc,
                                               input int rd_cyc);
    int elapsed;
    elapsed = rd_cyc - load_cyc - 1;
    return (elapsed >= n) ? 32'd0 : 32'(n - elapsed);
endfunction

// edge after which the interrupt is high, load issued in load_cyc
function automatic int expected_irq_cycle(input int load_cyc, input int n);
    return load_cyc + 1 + n;
endfunction

`endif

// File: tb_mm_ram.sv
/*
 * mm_ram testbench
 * drives both ports and the interrupt acknowledge, checks responses,
 * status pulses and the timer interrupt against a reference model
 */
`timescale 1ns/10ps

module tb_mm_ram;

    import mm_ram_pkg::*;

    `include "tb_mm_ram_model.svh"

    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_LOAD     = 40;
    localparam logic [15:0] WIN_BASE     = 16'hff00;
    // rough length of each test in cycles
    localparam int LEN_RAM        = 150;
    localparam int LEN_FETCH      = 30;
    localparam int LEN_STATUS     = 20;
    localparam int LEN_TIMER      = 2 * (MAX_LOAD + 12);
    localparam int LEN_ERR        = 12;
    localparam int TIMEOUT_CYCLES =
        2 * (LEN_RAM + LEN_FETCH + LEN_STATUS + LEN_TIMER + LEN_ERR) + RESET_CYCLES;

    logic         clk_i;
    logic         rst_ni;
    logic         instr_req_i;
    logic [15:0]  instr_addr_i;
    logic         instr_gnt_o;
    logic         instr_rvalid_o;
    logic [127:0] instr_rdata_o;
    logic         data_req_i;
    logic [31:0]  data_addr_i;
    logic         data_we_i;
    logic [3:0]   data_be_i;
    logic [31:0]  data_wdata_i;
    logic         data_gnt_o;
    logic         data_rvalid_o;
    logic [31:0]  data_rdata_o;
    logic         data_err_o;
    logic [4:0]   irq_id_i;
    logic         irq_ack_i;
    logic         irq_timer_o;
    logic         tests_passed_o;
    logic         tests_failed_o;
    logic         exit_valid_o;
    logic [31:0]  exit_value_o;

    // outstanding requests, oldest first
    logic [31:0]  exp_rdata_q[$];
    bit           chk_rdata_q[$];
    bit           exp_err_q[$];
    logic [127:0] exp_line_q[$];

    int stim_cyc;
    int cycle_count;
    bit data_seen;
    bit instr_seen;

    mm_ram_top i_dut (.*);

    always #2 clk_i = ~clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else
            stop_on_error($sformatf("FAILED at %0t: %s expected %0h, got %0h",
                                    $time, name, exp, act));
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        stim_cyc++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            data_req_i  <= 1'b0;
            instr_req_i <= 1'b0;
            irq_ack_i   <= 1'b0;
        end
    endtask

    // one data port request together with its expected response
    task automatic issue(input logic [31:0] addr, input logic we, input logic [3:0] be,
                         input logic [31:0] wdata, input bit chk,
                         input logic [31:0] exp_rdata, input bit exp_err);
        next_cycle();
        data_req_i   <= 1'b1;
        data_addr_i  <= addr;
        data_we_i    <= we;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        instr_req_i  <= 1'b0;
        irq_ack_i    <= 1'b0;
        exp_rdata_q.push_back(exp_rdata);
        chk_rdata_q.push_back(chk);
        exp_err_q.push_back(exp_err);
    endtask

    task automatic ram_write(input logic [15:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        model_write(addr, be, wdata);
        issue({16'h0, addr}, 1'b1, be, wdata, 1'b0, '0, 1'b0);
    endtask

    task automatic ram_read(input logic [15:0] addr);
        issue({16'h0, addr}, 1'b0, 4'hf, '0, 1'b1, model_read_word(addr), 1'b0);
    endtask

    task automatic fetch(input logic [15:0] addr);
        next_cycle();
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        data_req_i   <= 1'b0;
        irq_ack_i    <= 1'b0;
        exp_line_q.push_back(model_fetch_line(addr));
    endtask

    task automatic send_ack(input logic [4:0] id);
        next_cycle();
        irq_ack_i   <= 1'b1;
        irq_id_i    <= id;
        data_req_i  <= 1'b0;
        instr_req_i <= 1'b0;
    endtask

    // status and exit pulses, sampled away from the clock edge
    task automatic check_pulses(input logic [1:0] exp_status, input logic exp_exit);
        @(negedge clk_i);
        check_value("tests_passed_o", exp_status[1], tests_passed_o);
        check_value("tests_failed_o", exp_status[0], tests_failed_o);
        check_value("exit_valid_o", exp_exit, exit_valid_o);
    endtask

    // response checker, runs mid-cycle when all DUT outputs have settled
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            data_seen  = 1'b0;
            instr_seen = 1'b0;
        end else begin
            check_value("data_gnt_o", data_req_i, data_gnt_o);
            check_value("instr_gnt_o", instr_req_i, instr_gnt_o);
            check_value("data_rvalid_o", data_seen, data_rvalid_o);
            check_value("instr_rvalid_o", instr_seen, instr_rvalid_o);
            if (data_rvalid_o) begin
                if (exp_err_q.size() == 0) begin
                    stop_on_error("data response arrived with no request outstanding");
                end else begin
                    check_value("data_err_o", exp_err_q.pop_front(), data_err_o);
                    if (chk_rdata_q.pop_front()) begin
                        check_value("data_rdata_o", exp_rdata_q[0], data_rdata_o);
                    end
                    void'(exp_rdata_q.pop_front());
                end
            end
            if (instr_rvalid_o) begin
                if (exp_line_q.size() == 0) begin
                    stop_on_error("fetch response arrived with no request outstanding");
                end else begin
                    check_value("instr_rdata_o", exp_line_q.pop_front(), instr_rdata_o);
                end
            end
            // every request is granted in its own cycle
            data_seen  = data_req_i;
            instr_seen = instr_req_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles, tests did not finish",
                                    cycle_count));
        end
    end

    initial begin
        int          n;
        int          k;
        int          load_cyc;
        int          rise;
        logic [31:0] v;
        logic [31:0] mask;
        logic [15:0] a;
        logic [4:0]  id;

        void'($urandom(32'ha7a5aa35));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        stim_cyc     = 0;
        cycle_count  = 0;

        repeat (RESET_CYCLES) next_cycle();
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("irq_timer_o", 1'b0, irq_timer_o);
        check_value("data_err_o", 1'b0, data_err_o);
        check_pulses(2'b00, 1'b0);

        // RAM: fill a window, scatter byte-masked writes, read back to back
        for (int i = 0; i < 64; i++) begin
            a = WIN_BASE + 16'(4 * i);
            ram_write(a, 4'hf, fill_word(a));
        end
        for (int i = 0; i < 40; i++) begin
            ram_write(WIN_BASE + 16'($urandom % 256), 4'($urandom), $urandom);
        end
        for (int i = 0; i < 40; i++) begin
            ram_read(WIN_BASE + 16'($urandom % 256));
        end
        idle(2);

        // instruction fetches, mostly back to back with a few gaps
        for (int i = 0; i < 24; i++) begin
            if ($urandom % 4 == 0) begin
                idle(1);
            end else begin
                fetch(WIN_BASE + 16'($urandom % 256));
            end
        end
        idle(2);

        // test status values and the exit register
        for (int i = 0; i < 4; i++) begin
            v = (i == 0) ? 32'd123456789 : (i == 1) ? 32'd1 : (i == 2) ? 32'd0 : $urandom;
            if (i == 3 && (v == 32'd123456789 || v == 32'd1)) begin
                v = 32'd2;
            end
            issue(TEST_STATUS_ADDR, 1'b1, 4'hf, v, 1'b0, '0, 1'b0);
            idle(1);
            check_pulses(expected_status(v), 1'b0);
            idle(1);
            check_pulses(2'b00, 1'b0);
        end
        v = $urandom;
        issue(EXIT_ADDR, 1'b1, 4'hf, v, 1'b0, '0, 1'b0);
        idle(1);
        check_pulses(2'b00, 1'b1);
        check_value("exit_value_o", v, exit_value_o);
        idle(1);
        check_pulses(2'b00, 1'b0);
        check_value("exit_value_o", v, exit_value_o);

        // timer with the interrupt enabled
        mask = $urandom | 32'h80;
        n    = 2 + $urandom % (MAX_LOAD - 1);
        issue(TIMER_MASK_ADDR, 1'b1, 4'hf, mask, 1'b0, '0, 1'b0);
        issue(TIMER_CNT_ADDR, 1'b1, 4'hf, 32'(n), 1'b0, '0, 1'b0);
        load_cyc = stim_cyc;
        rise     = expected_irq_cycle(load_cyc, n);
        while (stim_cyc < rise + 1) begin
            idle(1);
            @(negedge clk_i);
            check_value("irq_timer_o", stim_cyc >= rise, irq_timer_o);
        end
        id = 5'($urandom % 32);
        if (id == 5'd7) begin
            id = 5'd8;
        end
        send_ack(id);
        idle(1);
        @(negedge clk_i);
        check_value("irq_timer_o", 1'b1, irq_timer_o);
        send_ack(5'd7);
        @(negedge clk_i);
        check_value("irq_timer_o", 1'b1, irq_timer_o);
        idle(1);
        @(negedge clk_i);
        check_value("irq_timer_o", 1'b0, irq_timer_o);

        // timer with the mask clear, plus mask and count readback
        mask = $urandom & ~32'h80;
        n    = 2 + $urandom % (MAX_LOAD - 1);
        issue(TIMER_MASK_ADDR, 1'b1, 4'hf, mask, 1'b0, '0, 1'b0);
        issue(TIMER_CNT_ADDR, 1'b1, 4'hf, 32'(n), 1'b0, '0, 1'b0);
        load_cyc = stim_cyc;
        issue(TIMER_MASK_ADDR, 1'b0, 4'hf, '0, 1'b1, mask, 1'b0);
        k = $urandom % n;
        for (int i = 0; i < n + 4; i++) begin
            if (i == k) begin
                issue(TIMER_CNT_ADDR, 1'b0, 4'hf, '0, 1'b1,
                      expected_count(n, load_cyc, stim_cyc + 1), 1'b0);
            end else begin
                idle(1);
            end
            @(negedge clk_i);
            check_value("irq_timer_o", 1'b0, irq_timer_o);
        end
        issue(TIMER_CNT_ADDR, 1'b0, 4'hf, '0, 1'b1,
              expected_count(n, load_cyc, stim_cyc + 1), 1'b0);

        // unmapped and write-only reads fail, unmapped writes change nothing
        issue(TEST_STATUS_ADDR, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1);
        issue(EXIT_ADDR, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1);
        issue(32'h3000_0000, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1);
        issue(32'h1500_0008, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1);
        a = WIN_BASE + 16'(4 * ($urandom % 64));
        issue({16'h0001, a}, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1);
        issue({16'h0001, a}, 1'b1, 4'hf, ~model_read_word(a), 1'b0, '0, 1'b0);
        issue(32'h1500_1000, 1'b1, 4'hf, $urandom, 1'b0, '0, 1'b0);
        ram_read(a);
        idle(3);

        if (exp_err_q.size() != 0 || exp_line_q.size() != 0) begin
            stop_on_error("some requests never received a response");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: mm_ram_top.sv
/*
 * mm_ram top level
 * RAM plus pseudo peripherals (timer, test status, exit) behind a
 * wide instruction fetch port and a 32-bit data port
 */
`timescale 1ns/10ps

module mm_ram_top (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,

    input  logic                                   instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                                   instr_gnt_o,
    output logic                                   instr_rvalid_o,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                                   data_req_i,
    input  logic [mm_ram_pkg::ADDR_WIDTH-1:0]        data_addr_i,
    input  logic                                   data_we_i,
    input  logic [mm_ram_pkg::BE_WIDTH-1:0]          data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_wdata_i,
    output logic                                   data_gnt_o,
    output logic                                   data_rvalid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_rdata_o,
    output logic                                   data_err_o,

    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0]      irq_id_i,
    input  logic                                   irq_ack_i,
    output logic                                   irq_timer_o,

    output logic                                   tests_passed_o,
    output logic                                   tests_failed_o,
    output logic                                   exit_valid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]        exit_value_o
);

    import mm_ram_pkg::*;

    logic                  ram_req;
    logic                  reg_req;
    ctrl_reg_e             reg_op;
    rdata_sel_e            sel;
    logic [DATA_WIDTH-1:0] ram_rdata;
    logic [DATA_WIDTH-1:0] reg_rdata;
    logic                  timer_load;
    logic                  timer_hold;
    logic                  timer_irq_en;
    logic [DATA_WIDTH-1:0] timer_count;

    // memory never stalls, so every request is granted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    mm_ram_decoder i_decoder (
        .data_req_i  ( data_req_i  ),
        .data_addr_i ( data_addr_i ),
        .data_we_i   ( data_we_i   ),
        .ram_req_o   ( ram_req     ),
        .reg_req_o   ( reg_req     ),
        .reg_op_o    ( reg_op      ),
        .sel_o       ( sel         )
    );

    mm_ram_mem i_mem (
        .clk_i          ( clk_i                            ),
        .rst_ni         ( rst_ni                           ),
        .instr_req_i    ( instr_req_i                      ),
        .instr_addr_i   ( instr_addr_i                     ),
        .instr_rdata_o  ( instr_rdata_o                    ),
        .instr_rvalid_o ( instr_rvalid_o                   ),
        .data_req_i     ( ram_req                          ),
        .data_addr_i    ( data_addr_i[RAM_ADDR_WIDTH-1:0]  ),
        .data_we_i      ( data_we_i                        ),
        .data_be_i      ( data_be_i                        ),
        .data_wdata_i   ( data_wdata_i                     ),
        .data_rdata_o   ( ram_rdata                        )
    );

    mm_ram_ctrl_regs i_ctrl_regs (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .reg_req_i      ( reg_req        ),
        .reg_op_i       ( reg_op         ),
        .we_i           ( data_we_i      ),
        .wdata_i        ( data_wdata_i   ),
        .timer_count_i  ( timer_count    ),
        .timer_load_o   ( timer_load     ),
        .timer_hold_o   ( timer_hold     ),
        .timer_irq_en_o ( timer_irq_en   ),
        .rdata_o        ( reg_rdata      ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

    mm_ram_timer i_timer (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .load_i       ( timer_load   ),
        .load_value_i ( data_wdata_i ),
        .hold_i       ( timer_hold   ),
        .irq_en_i     ( timer_irq_en ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_id_i     ( irq_id_i     ),
        .count_o      ( timer_count  ),
        .irq_o        ( irq_timer_o  )
    );

    mm_ram_rsp_mux i_rsp_mux (
        .clk_i       ( clk_i         ),
        .rst_ni      ( rst_ni        ),
        .req_i       ( data_req_i    ),
        .sel_i       ( sel           ),
        .ram_rdata_i ( ram_rdata     ),
        .reg_rdata_i ( reg_rdata     ),
        .rvalid_o    ( data_rvalid_o ),
        .rdata_o     ( data_rdata_o  ),
        .err_o       ( data_err_o    )
    );

endmodule

// File: mm_ram_rsp_mux.sv
/*
 * data port response stage
 * one-cycle rvalid and read data selection between RAM, registers and error
 */
`timescale 1ns/10ps

module mm_ram_rsp_mux (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_i,
    input  mm_ram_pkg::rdata_sel_e          sel_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] ram_rdata_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] reg_rdata_i,
    output logic                            rvalid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                            err_o
);

    import mm_ram_pkg::*;

    logic       rvalid_q;
    rdata_sel_e sel_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            sel_q    <= SEL_RAM;
        end else begin
            rvalid_q <= req_i;
            sel_q    <= sel_i;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_RAM: rdata_o = ram_rdata_i;
            SEL_REG: rdata_o = reg_rdata_i;
            default: rdata_o = '0;
        endcase
    end

    // error only qualifies a response that is actually returned
    assign err_o    = rvalid_q && (sel_q == SEL_ERR);
    assign rvalid_o = rvalid_q;

endmodule

// File: mm_ram_timer.sv
/*
 * countdown timer
 * raises a maskable interrupt when the count steps from 1 to 0
 */
`timescale 1ns/10ps

module mm_ram_timer (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              load_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]   load_value_i,
    input  logic                              hold_i,
    input  logic                              irq_en_i,
    input  logic                              irq_ack_i,
    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]   count_o,
    output logic                              irq_o
);

    import mm_ram_pkg::*;

    logic [DATA_WIDTH-1:0] count_q;
    logic                  irq_q;
    logic                  step;
    logic                  expire;
    logic                  ack;

    assign step   = !load_i && !hold_i && (count_q != '0);
    assign expire = step && (count_q == DATA_WIDTH'(1));
    assign ack    = irq_ack_i && (irq_id_i == IRQ_ID_WIDTH'(TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (load_i) begin
                count_q <= load_value_i;
            end else if (step) begin
                count_q <= count_q - DATA_WIDTH'(1);
            end

            // acknowledge wins over a simultaneous expiry
            if (ack) begin
                irq_q <= 1'b0;
            end else if (expire && irq_en_i) begin
                irq_q <= 1'b1;
            end
        end
    end

    assign count_o = count_q;
    assign irq_o   = irq_q;

endmodule

// File: mm_ram_ctrl_regs.sv
/*
 * control and status registers
 * timer mask, test status pulses, exit value and register readback
 */
`timescale 1ns/10ps

module mm_ram_ctrl_regs (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            reg_req_i,
    input  mm_ram_pkg::ctrl_reg_e           reg_op_i,
    input  logic                            we_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0] timer_count_i,
    output logic                            timer_load_o,
    output logic                            timer_hold_o,
    output logic                            timer_irq_en_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                            tests_passed_o,
    output logic                            tests_failed_o,
    output logic                            exit_valid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0] exit_value_o
);

    import mm_ram_pkg::*;

    logic                  reg_wr;
    logic                  reg_rd;
    logic [DATA_WIDTH-1:0] mask_q;
    logic [DATA_WIDTH-1:0] rdata_d;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  passed_q;
    logic                  failed_q;
    logic                  exit_valid_q;
    logic [DATA_WIDTH-1:0] exit_value_q;

    assign reg_wr = reg_req_i && we_i;
    assign reg_rd = reg_req_i && !we_i;

    // any register write pauses the countdown for that cycle
    assign timer_hold_o   = reg_wr;
    assign timer_load_o   = reg_wr && (reg_op_i == CR_TIMER_CNT);
    assign timer_irq_en_o = mask_q[TIMER_IRQ_ID];

    always_comb begin
        rdata_d = '0;
        if (reg_rd) begin
            case (reg_op_i)
                CR_TIMER_MASK: rdata_d = mask_q;
                CR_TIMER_CNT:  rdata_d = timer_count_i;
                default:       rdata_d = '0;
            endcase
        end
    end

    // readback lines up with the RAM read data in the rvalid cycle
    always_ff @(posedge clk_i) begin
        rdata_q <= rdata_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q       <= '0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
        end else begin
            if (reg_wr && reg_op_i == CR_TIMER_MASK) begin
                mask_q <= wdata_i;
            end
            passed_q     <= reg_wr && (reg_op_i == CR_TEST_STATUS) && (wdata_i == TEST_PASS_CODE);
            failed_q     <= reg_wr && (reg_op_i == CR_TEST_STATUS) && (wdata_i == TEST_FAIL_CODE);
            exit_valid_q <= reg_wr && (reg_op_i == CR_EXIT);
            if (reg_wr && reg_op_i == CR_EXIT) begin
                exit_value_q <= wdata_i;
            end
        end
    end

    assign rdata_o        = rdata_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

endmodule

// File: mm_ram_mem.sv
/*
 * dual port byte-addressed RAM
 * port A fetches a 128-bit aligned line, port B is a byte-enabled data port
 */
`timescale 1ns/10ps

module mm_ram_mem (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,

    input  logic                                   instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    output logic                                   instr_rvalid_o,

    input  logic                                   data_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]    data_addr_i,
    input  logic                                   data_we_i,
    input  logic [mm_ram_pkg::BE_WIDTH-1:0]          data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_wdata_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]        data_rdata_o
);

    import mm_ram_pkg::*;

    logic [7:0]                   mem [0:RAM_SIZE-1];
    logic [RAM_ADDR_WIDTH-1:0]    instr_base;
    logic [RAM_ADDR_WIDTH-1:0]    data_base;
    logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_q;
    logic [DATA_WIDTH-1:0]        data_rdata_q;
    logic                         instr_rvalid_q;

    // fetch lines are 16-byte aligned, data words 4-byte aligned
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:4], 4'b0};
    assign data_base  = {data_addr_i[RAM_ADDR_WIDTH-1:2], 2'b0};

    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            // lowest address ends up in the least significant byte
            for (int b = 0; b < INSTR_BYTES; b++) begin
                instr_rdata_q[8*b +: 8] <= mem[instr_base + RAM_ADDR_WIDTH'(b)];
            end
        end

        if (data_req_i) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
                if (data_we_i && data_be_i[b]) begin
                    mem[data_base + RAM_ADDR_WIDTH'(b)] <= data_wdata_i[8*b +: 8];
                end
                data_rdata_q[8*b +: 8] <= mem[data_base + RAM_ADDR_WIDTH'(b)];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    assign instr_rdata_o  = instr_rdata_q;
    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rdata_o   = data_rdata_q;

endmodule

// File: mm_ram_decoder.sv
/*
 * data port address decoder
 * steers each request to the RAM, to a control register or to the error path
 */
`timescale 1ns/10ps

module mm_ram_decoder (
    input  logic                            data_req_i,
    input  logic [mm_ram_pkg::ADDR_WIDTH-1:0] data_addr_i,
    input  logic                            data_we_i,
    output logic                            ram_req_o,
    output logic                            reg_req_o,
    output mm_ram_pkg::ctrl_reg_e           reg_op_o,
    output mm_ram_pkg::rdata_sel_e          sel_o
);

    import mm_ram_pkg::*;

    logic hit_ram;
    logic hit_mask;
    logic hit_cnt;
    logic hit_status;
    logic hit_exit;

    // RAM occupies everything below 2^RAM_ADDR_WIDTH
    assign hit_ram    = (data_addr_i[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0);
    assign hit_mask   = (data_addr_i == TIMER_MASK_ADDR);
    assign hit_cnt    = (data_addr_i == TIMER_CNT_ADDR);
    assign hit_status = (data_addr_i == TEST_STATUS_ADDR);
    assign hit_exit   = (data_addr_i == EXIT_ADDR);

    always_comb begin
        ram_req_o = 1'b0;
        reg_req_o = 1'b0;
        reg_op_o  = CR_TIMER_MASK;
        sel_o     = SEL_RAM;

        if (hit_ram) begin
            ram_req_o = data_req_i;
        end else if (hit_mask) begin
            reg_req_o = data_req_i;
            reg_op_o  = CR_TIMER_MASK;
            sel_o     = SEL_REG;
        end else if (hit_cnt) begin
            reg_req_o = data_req_i;
            reg_op_o  = CR_TIMER_CNT;
            sel_o     = SEL_REG;
        end else if (data_we_i) begin
            // writes elsewhere complete with zero data and no error
            sel_o = SEL_REG;
            if (hit_status) begin
                reg_req_o = data_req_i;
                reg_op_o  = CR_TEST_STATUS;
            end else if (hit_exit) begin
                reg_req_o = data_req_i;
                reg_op_o  = CR_EXIT;
            end
        end else begin
            // status and exit are write-only, so reads land here too
            sel_o = SEL_ERR;
        end
    end

endmodule

// File: mm_ram_pkg.sv
/*
 * mm_ram shared definitions
 * widths, the peripheral address map, status codes and the enums used
 * between the data port decoder, the register block and the response mux
 */
package mm_ram_pkg;

    // RAM geometry
    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int RAM_SIZE          = 2 ** RAM_ADDR_WIDTH;

    // instruction fetch returns four data words per request
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int INSTR_BYTES       = INSTR_RDATA_WIDTH / 8;

    // data port
    localparam int ADDR_WIDTH        = 32;
    localparam int DATA_WIDTH        = 32;
    localparam int BE_WIDTH          = 4;

    // interrupt id as seen on the acknowledge interface
    localparam int IRQ_ID_WIDTH      = 5;

    // pseudo peripheral address map
    localparam logic [ADDR_WIDTH-1:0] TIMER_MASK_ADDR  = 32'h1500_0000;
    localparam logic [ADDR_WIDTH-1:0] TIMER_CNT_ADDR   = 32'h1500_0004;
    localparam logic [ADDR_WIDTH-1:0] TEST_STATUS_ADDR = 32'h2000_0000;
    localparam logic [ADDR_WIDTH-1:0] EXIT_ADDR        = 32'h2000_0004;

    // values written to the test status register
    localparam logic [DATA_WIDTH-1:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [DATA_WIDTH-1:0] TEST_FAIL_CODE = 32'd1;

    // mask bit and acknowledge id of the timer interrupt
    localparam int TIMER_IRQ_ID = 7;

    // source of the data port read data in the response cycle
    typedef enum logic [1:0] {
        SEL_RAM = 2'd0,
        SEL_REG = 2'd1,
        SEL_ERR = 2'd2
    } rdata_sel_e;

    // register operation targeted by a data port access
    typedef enum logic [1:0] {
        CR_TIMER_MASK  = 2'd0,
        CR_TIMER_CNT   = 2'd1,
        CR_TEST_STATUS = 2'd2,
        CR_EXIT        = 2'd3
    } ctrl_reg_e;

endpackage
